// File: channel_mixer.sv
// ----------------------------------------------------------
// sequential multiply-accumulate mixer with 24-bit clamp
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module channel_mixer
    import dmix_pkg::*;
#(
    parameter int NUM_IN = 2
) (
    input  logic                       clk491520,
    input  logic                       rst_ip,

    input  logic [NUM_IN*sample_w-1:0] left_i,
    input  logic [NUM_IN*sample_w-1:0] right_i,
    input  logic [NUM_IN*vol_w-1:0]    vol_i,

    input  logic                       pop_i,
    input  logic                       chan_i,
    output logic [sample_w-1:0]        data_o,
    output logic                       ack_o
);

    localparam int idx_w  = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;
    localparam int prod_w = sample_w + vol_w + 1;
    // shifted product plus headroom for up to four sources
    localparam int acc_w  = sample_w + vol_w - 14 + 3;

    localparam logic signed [acc_w-1:0] sat_max = acc_w'((1 << (sample_w - 1)) - 1);
    localparam logic signed [acc_w-1:0] sat_min = -sat_max - 1;

    mix_state_e                state;
    logic [idx_w-1:0]          src_idx;
    logic                      chan_q;
    logic signed [acc_w-1:0]   acc;
    logic [sample_w-1:0]       cur_sample;
    logic [vol_w-1:0]          cur_vol;
    logic signed [prod_w-1:0]  prod;
    logic signed [prod_w-1:0]  prod_sh;
    logic [sample_w-1:0]       sat_word;

    assign cur_sample = chan_q ? right_i[src_idx*sample_w +: sample_w]
                               : left_i[src_idx*sample_w +: sample_w];
    assign cur_vol    = vol_i[src_idx*vol_w +: vol_w];

    // volume is unsigned, so pad a zero sign bit
    assign prod    = $signed(cur_sample) * $signed({1'b0, cur_vol});
    assign prod_sh = prod >>> 14;

    always_comb begin
        if (acc > sat_max) begin
            sat_word = {1'b0, {(sample_w - 1){1'b1}}};
        end else if (acc < sat_min) begin
            sat_word = {1'b1, {(sample_w - 1){1'b0}}};
        end else begin
            sat_word = acc[sample_w-1:0];
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            state   <= MIX_IDLE;
            src_idx <= '0;
            ack_o   <= 1'b0;
        end else begin
            ack_o <= 1'b0;
            case (state)
                MIX_IDLE: if (pop_i) begin
                    src_idx <= '0;
                    state   <= MIX_ACC;
                end
                MIX_ACC: begin
                    src_idx <= src_idx + 1'b1;
                    if (src_idx == idx_w'(NUM_IN - 1)) begin
                        state <= MIX_SAT;
                    end
                end
                MIX_SAT: begin
                    ack_o <= 1'b1;
                    state <= MIX_IDLE;
                end
                default: state <= MIX_IDLE;
            endcase
        end
    end

    // channel latch and accumulator, restarted on each pop
    always_ff @(posedge clk491520) begin
        if (state == MIX_IDLE && pop_i) begin
            chan_q <= chan_i;
            acc    <= '0;
        end else if (state == MIX_ACC) begin
            acc <= acc + $signed(prod_sh[acc_w-1:0]);
        end
        if (state == MIX_SAT) begin
            data_o <= sat_word;
        end
    end

endmodule

`default_nettype wire

// File: dac_drv.sv
// ----------------------------------------------------------
// i2s dac driver: bck/lrck generation, word requests, shifter
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dac_drv
    import dmix_pkg::*;
(
    input  logic                clk491520,
    input  logic                rst_ip,

    input  logic [sample_w-1:0] data_i,
    input  logic                ack_i,
    output logic                pop_o,
    output logic                chan_o,

    output logic                bck_o,
    output logic                lrck_o,
    output logic                data_o
);

    dac_state_e          state;
    logic [1:0]          div_cnt;
    logic [4:0]          bit_cnt;
    logic [sample_w-1:0] shreg;
    logic                fall;
    logic                slot_start;

    // bck about to drop on this edge
    assign fall       = bck_o && (div_cnt == 2'd3);
    assign slot_start = fall && (bit_cnt == 5'd31);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            div_cnt <= '0;
            bit_cnt <= 5'd31;
            bck_o   <= 1'b0;
            lrck_o  <= 1'b0;
            // pretend the last slot was right, so the first one is left
            chan_o  <= 1'b1;
            pop_o   <= 1'b0;
            data_o  <= 1'b0;
            state   <= DAC_WAIT;
        end else begin
            div_cnt <= div_cnt + 2'd1;
            pop_o   <= slot_start;
            if (div_cnt == 2'd3) begin
                bck_o <= ~bck_o;
            end
            if (fall) begin
                bit_cnt <= bit_cnt + 5'd1;
                data_o  <= 1'b0;
            end
            if (slot_start) begin
                lrck_o <= ~chan_o;
                chan_o <= ~chan_o;
            end
            case (state)
                DAC_WAIT: if (ack_i) state <= DAC_SHIFT;
                DAC_SHIFT: if (fall) begin
                    // msb goes out one bck after the lrck change
                    data_o <= shreg[sample_w-1];
                    if (bit_cnt == 5'd23) begin
                        state <= DAC_PAD;
                    end
                end
                DAC_PAD: if (slot_start) state <= DAC_WAIT;
                default: state <= DAC_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk491520) begin
        if (state == DAC_WAIT && ack_i) begin
            shreg <= data_i;
        end else if (state == DAC_SHIFT && fall) begin
            shreg <= {shreg[sample_w-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: dmix_chk.sv
// ----------------------------------------------------------
// bound checker: mixer handshake and dac framing assertions
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dmix_chk #(
    parameter int NUM_IN = 2
) (
    input wire clk491520,
    input wire rst_ip,
    input wire pop_i,
    input wire ack_i,
    input wire bck_i,
    input wire lrck_i
);

    logic busy;

    // one request in flight between pop and ack
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            busy <= 1'b0;
        end else if (pop_i) begin
            busy <= 1'b1;
        end else if (ack_i) begin
            busy <= 1'b0;
        end
    end

    ack_latency: assert property (@(posedge clk491520) disable iff (rst_ip)
        pop_i |-> ##(NUM_IN + 2) ack_i) else $error("ack missing after pop");

    ack_exact: assert property (@(posedge clk491520) disable iff (rst_ip)
        ack_i |-> $past(pop_i, NUM_IN + 2)) else $error("ack with wrong latency");

    no_overlap: assert property (@(posedge clk491520) disable iff (rst_ip)
        pop_i |-> !busy) else $error("pop while request outstanding");

    lrck_on_fall: assert property (@(posedge clk491520) disable iff (rst_ip)
        $changed(lrck_i) |-> $fell(bck_i)) else $error("lrck moved off a falling bck");

    // the msb leaves on the first bck fall after the pop
    ack_before_msb: assert property (@(posedge clk491520) disable iff (rst_ip)
        $fell(bck_i) |-> !$past(busy)) else $error("ack too late for the first data bit");

endmodule

bind dmix_top dmix_chk #(.NUM_IN(NUM_IN)) chk (
    .clk491520(clk491520), .rst_ip(rst_ip), .pop_i(mix_pop), .ack_i(mix_ack),
    .bck_i(dac_bck_o), .lrck_i(dac_lrck_o));

`default_nettype wire

// File: dmix_pkg.sv
// ----------------------------------------------------------
// shared widths, volume format and FSM state encodings
// ----------------------------------------------------------
`default_nettype none

package dmix_pkg;

    // audio sample width, two's complement
    localparam int sample_w = 24;

    // volume word, unsigned Q2.14
    localparam int vol_w = 16;

    // gain of exactly 1.0 in Q2.14
    localparam logic [vol_w-1:0] vol_unity = 16'h4000;

    // mixer sequencing
    typedef enum logic [1:0] {
        MIX_IDLE,
        MIX_ACC,
        MIX_SAT
    } mix_state_e;

    // dac slot handling
    typedef enum logic [1:0] {
        DAC_WAIT,
        DAC_SHIFT,
        DAC_PAD
    } dac_state_e;

endpackage

`default_nettype wire

// File: dmix_top.sv
// ----------------------------------------------------------
// mixer top level: intake, mac mixer and i2s dac driver
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dmix_top
    import dmix_pkg::*;
#(
    parameter int NUM_IN = 2
) (
    input  logic                       clk491520,
    input  logic                       rst_ip,

    input  logic [NUM_IN*sample_w-1:0] sample_i,
    input  logic [NUM_IN-1:0]          lrck_i,
    input  logic [NUM_IN-1:0]          valid_i,
    input  logic [NUM_IN-1:0]          locked_i,
    input  logic [NUM_IN*vol_w-1:0]    vol_i,

    output logic                       dac_bck_o,
    output logic                       dac_lrck_o,
    output logic                       dac_data_o
);

    logic [NUM_IN*sample_w-1:0] left;
    logic [NUM_IN*sample_w-1:0] right;
    logic                       mix_pop;
    logic                       mix_chan;
    logic                       mix_ack;
    logic [sample_w-1:0]        mix_data;

    sample_intake #(.NUM_IN(NUM_IN)) intake (
        .clk491520(clk491520), .rst_ip(rst_ip),
        .sample_i(sample_i), .lrck_i(lrck_i), .valid_i(valid_i), .locked_i(locked_i),
        .left_o(left), .right_o(right));

    channel_mixer #(.NUM_IN(NUM_IN)) mixer (
        .clk491520(clk491520), .rst_ip(rst_ip),
        .left_i(left), .right_i(right), .vol_i(vol_i),
        .pop_i(mix_pop), .chan_i(mix_chan), .data_o(mix_data), .ack_o(mix_ack));

    // the dac paces every request
    dac_drv dac (
        .clk491520(clk491520), .rst_ip(rst_ip),
        .data_i(mix_data), .ack_i(mix_ack), .pop_o(mix_pop), .chan_o(mix_chan),
        .bck_o(dac_bck_o), .lrck_o(dac_lrck_o), .data_o(dac_data_o));

endmodule

`default_nettype wire

// File: flist.f
dmix_pkg.sv
sample_intake.sv
channel_mixer.sv
dac_drv.sv
dmix_top.sv
dmix_chk.sv
tb_dmix.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dmix testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_dmix -o sim_dmix
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_dmix > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sample_intake.sv
// ----------------------------------------------------------
// per-source left/right sample holding with lock muting
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_intake
    import dmix_pkg::*;
#(
    parameter int NUM_IN = 2
) (
    input  logic                       clk491520,
    input  logic                       rst_ip,

    input  logic [NUM_IN*sample_w-1:0] sample_i,
    input  logic [NUM_IN-1:0]          lrck_i,
    input  logic [NUM_IN-1:0]          valid_i,
    input  logic [NUM_IN-1:0]          locked_i,

    output logic [NUM_IN*sample_w-1:0] left_o,
    output logic [NUM_IN*sample_w-1:0] right_o
);

    for (genvar i = 0; i < NUM_IN; i++) begin : g_src
        logic [sample_w-1:0] left_q;
        logic [sample_w-1:0] right_q;
        logic [sample_w-1:0] src_sample;

        assign src_sample = sample_i[i*sample_w +: sample_w];

        always_ff @(posedge clk491520) begin
            if (rst_ip) begin
                left_q  <= '0;
                right_q <= '0;
            end else if (!locked_i[i]) begin
                // unlocked source must not leak its last samples
                left_q  <= '0;
                right_q <= '0;
            end else if (valid_i[i]) begin
                // lrck high marks the right channel word
                if (lrck_i[i]) begin
                    right_q <= src_sample;
                end else begin
                    left_q <= src_sample;
                end
            end
        end

        assign left_o[i*sample_w +: sample_w]  = left_q;
        assign right_o[i*sample_w +: sample_w] = right_q;
    end

endmodule

`default_nettype wire

// File: tb_dmix.sv
// ----------------------------------------------------------
// testbench for dmix_top: i2s capture, reference model, tests
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dmix
    import dmix_pkg::*;
();

    localparam int NUM_IN = 2;

    logic                       clk491520 = 1'b0;
    logic                       rst_ip;
    logic [NUM_IN*sample_w-1:0] sample_i;
    logic [NUM_IN-1:0]          lrck_i;
    logic [NUM_IN-1:0]          valid_i;
    logic [NUM_IN-1:0]          locked_i;
    logic [NUM_IN*vol_w-1:0]    vol_i;
    wire                        dac_bck_o;
    wire                        dac_lrck_o;
    wire                        dac_data_o;

    // expected state of the intake registers and volumes
    logic [sample_w-1:0] held_l [NUM_IN];
    logic [sample_w-1:0] held_r [NUM_IN];
    logic [vol_w-1:0]    vol_m [NUM_IN];
    logic                lock_m [NUM_IN];

    logic [31:0]         lfsr_q = 32'h9400;
    int                  errors;
    int                  checks;
    int                  word_cnt;
    int                  rise_cnt;
    int                  first_chan;
    logic                bck_q;
    logic [sample_w-1:0] shift_w;
    logic [sample_w-1:0] last_word [2];

    dmix_top #(.NUM_IN(NUM_IN)) dut (
        .clk491520(clk491520), .rst_ip(rst_ip),
        .sample_i(sample_i), .lrck_i(lrck_i), .valid_i(valid_i), .locked_i(locked_i),
        .vol_i(vol_i),
        .dac_bck_o(dac_bck_o), .dac_lrck_o(dac_lrck_o), .dac_data_o(dac_data_o));

    always #10 clk491520 = ~clk491520;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [sample_w-1:0] mix_ref(input int ch);
        longint sum;
        longint prod;
        sum = 0;
        for (int i = 0; i < NUM_IN; i++) begin
            prod = longint'($signed(ch ? held_r[i] : held_l[i])) * longint'(vol_m[i]);
            sum  = sum + (prod >>> 14);
        end
        if (sum > 64'sd8388607) begin
            return 24'h7FFFFF;
        end else if (sum < -64'sd8388608) begin
            return 24'h800000;
        end
        return sum[sample_w-1:0];
    endfunction

    // i2s capture: one delay bit after each slot start, then 24 data bits
    always @(posedge clk491520) begin
        int pos;
        int slot;
        bck_q <= dac_bck_o;
        if (rst_ip) begin
            rise_cnt <= 0;
            word_cnt <= 0;
        end else if (!bck_q && dac_bck_o) begin
            rise_cnt <= rise_cnt + 1;
            if (rise_cnt >= 1) begin
                pos  = (rise_cnt - 1) % 32;
                slot = (rise_cnt - 1) / 32;
                if (pos == 0) begin
                    assert (dac_lrck_o == slot[0]) else begin
                        $display("word clock has the wrong level at %0t in slot %0d",
                                 $time, slot);
                        errors++;
                    end
                end
                if (pos >= 1 && pos <= 24) begin
                    shift_w = {shift_w[sample_w-2:0], dac_data_o};
                end
                if (pos == 24) begin
                    last_word[slot % 2] = shift_w;
                    if (word_cnt == 0) begin
                        first_chan = dac_lrck_o;
                    end
                    word_cnt <= word_cnt + 1;
                end
            end
        end
    end

    task automatic wait_words(input int n);
        int start;
        int t;
        start = word_cnt;
        t     = 0;
        while (word_cnt < start + n) begin
            @(posedge clk491520);
            t++;
            if (t > 300 * n) begin
                $display("timeout: the DAC stopped delivering words at %0t", $time);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    endtask

    // two full frames, then both channels against the model
    task automatic check_mix();
        logic [sample_w-1:0] exp;
        wait_words(5);
        for (int ch = 0; ch < 2; ch++) begin
            exp = mix_ref(ch);
            checks++;
            assert (last_word[ch] == exp) else begin
                $display("** Error at %0t: dac_data_o %s = %h, expected %h",
                         $time, ch ? "right" : "left", last_word[ch], exp);
                errors++;
            end
        end
    endtask

    task automatic send_sample(input int src, input logic ch, input logic [sample_w-1:0] v);
        @(posedge clk491520);
        sample_i[src*sample_w +: sample_w] <= v;
        lrck_i[src]  <= ch;
        valid_i[src] <= 1'b1;
        @(posedge clk491520);
        valid_i[src] <= 1'b0;
        if (lock_m[src] && ch) begin
            held_r[src] = v;
        end else if (lock_m[src]) begin
            held_l[src] = v;
        end
    endtask

    task automatic set_src(input int src, input logic lock, input logic [vol_w-1:0] vol);
        @(posedge clk491520);
        locked_i[src] <= lock;
        vol_i[src*vol_w +: vol_w] <= vol;
        lock_m[src] = lock;
        vol_m[src]  = vol;
        if (!lock) begin
            held_l[src] = '0;
            held_r[src] = '0;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic check_reset_levels();
        checks++;
        assert ({dac_bck_o, dac_lrck_o, dac_data_o} == 3'b000) else begin
            $display("** Error at %0t: dac_bck_o/dac_lrck_o/dac_data_o = %b, expected 000",
                     $time, {dac_bck_o, dac_lrck_o, dac_data_o});
            errors++;
        end
    endtask

    initial begin
        int          e0;
        logic [31:0] r;
        logic [31:0] v;
        rst_ip   = 1'b1;
        sample_i = '0;
        lrck_i   = '0;
        valid_i  = '0;
        locked_i = '0;
        vol_i    = '0;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < NUM_IN; i++) begin
            held_l[i] = '0;
            held_r[i] = '0;
            vol_m[i]  = '0;
            lock_m[i] = 1'b0;
        end

        e0 = errors;
        // outputs take their reset levels on the first edge
        @(posedge clk491520);
        repeat (3) begin
            @(posedge clk491520);
            check_reset_levels();
        end
        rst_ip <= 1'b0;
        @(posedge clk491520);
        check_reset_levels();
        wait_words(1);
        checks++;
        assert (first_chan == 0) else begin
            $display("** Error at %0t: dac_lrck_o in first slot = %0d, expected 0",
                     $time, first_chan);
            errors++;
        end
        end_test("reset", e0);

        e0 = errors;
        set_src(0, 1'b1, vol_unity);
        set_src(1, 1'b0, 16'h0000);
        send_sample(0, 1'b0, 24'h123456);
        send_sample(0, 1'b1, 24'hF00001);
        check_mix();
        end_test("pass_through", e0);

        e0 = errors;
        set_src(0, 1'b1, 16'h2000);
        set_src(1, 1'b1, 16'h5000);
        send_sample(0, 1'b0, 24'h200000);
        send_sample(0, 1'b1, 24'hE12345);
        send_sample(1, 1'b0, 24'hC00003);
        send_sample(1, 1'b1, 24'h0ABCDE);
        check_mix();
        end_test("weighted_sum", e0);

        e0 = errors;
        set_src(0, 1'b1, 16'hFFFF);
        set_src(1, 1'b1, 16'hFFFF);
        for (int i = 0; i < NUM_IN; i++) begin
            send_sample(i, 1'b0, 24'h700000);
            send_sample(i, 1'b1, 24'h900000);
        end
        check_mix();
        end_test("saturation", e0);

        e0 = errors;
        set_src(0, 1'b1, vol_unity);
        set_src(1, 1'b1, vol_unity);
        send_sample(1, 1'b0, 24'h054321);
        send_sample(1, 1'b1, 24'hFA0000);
        check_mix();
        set_src(1, 1'b0, vol_unity);
        check_mix();
        set_src(1, 1'b1, vol_unity);
        check_mix();
        send_sample(1, 1'b0, 24'h001234);
        send_sample(1, 1'b1, 24'hFFF000);
        check_mix();
        end_test("lock_muting", e0);

        e0 = errors;
        repeat (20) begin
            for (int i = 0; i < NUM_IN; i++) begin
                draw_bits(2, r);
                draw_bits(16, v);
                set_src(i, |r[1:0], v[vol_w-1:0]);
                draw_bits(24, v);
                send_sample(i, 1'b0, v[sample_w-1:0]);
                draw_bits(24, v);
                send_sample(i, 1'b1, v[sample_w-1:0]);
            end
            check_mix();
        end
        end_test("random", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
